// ==== axi_wm_consts.svh ====
`ifndef AXI_WM_CONSTS_SVH
`define AXI_WM_CONSTS_SVH

// AXI bus widths
`define AXI_WM_ADDR_W 32
`define AXI_WM_DATA_W 32
`define AXI_WM_STRB_W 4
`define AXI_WM_BYTE_IDX_W 2

// Width of the command byte count
`define AXI_WM_SIZE_W 32

// Full burst geometry, 256 beats of 4 bytes
`define AXI_WM_BURST_BEATS 256
`define AXI_WM_BURST_IDX_W 8
`define AXI_WM_BURST_BYTES 1024
`define AXI_WM_TXN_W 22

// Outstanding burst limit and buffering
`define AXI_WM_MAX_OUTSTANDING 32
`define AXI_WM_CREDIT_W 6
`define AXI_WM_FIFO_DEPTH 32

`endif

// ==== axi_wm_pkg.sv ====
`include "axi_wm_consts.svh"

package axi_wm_pkg;

  // Bus payload types
  typedef logic [`AXI_WM_ADDR_W-1:0] addr_t;
  typedef logic [`AXI_WM_DATA_W-1:0] data_t;
  typedef logic [`AXI_WM_STRB_W-1:0] strb_t;

  // Beat index inside one burst, same encoding as AWLEN
  typedef logic [`AXI_WM_BURST_IDX_W-1:0] beat_idx_t;

  // Bursts left in the command, minus one
  typedef logic [`AXI_WM_TXN_W-1:0] txn_cnt_t;

  // Data channel run state
  typedef enum logic {
    W_IDLE,
    W_RUN
  } w_state_t;

endpackage

// ==== wm_cmd_decode.sv ====
`timescale 1ns/1ps
`include "axi_wm_consts.svh"

module wm_cmd_decode (
  input  logic                          aclk,
  input  logic                          areset,
  input  logic                          ctrl_start,
  input  axi_wm_pkg::addr_t             ctrl_addr_offset,
  input  logic [`AXI_WM_SIZE_W-1:0]     ctrl_xfer_size_in_bytes,
  output logic                          start,
  output axi_wm_pkg::addr_t             base_addr,
  output axi_wm_pkg::txn_cnt_t          num_txn,
  output axi_wm_pkg::beat_idx_t         final_len,
  output axi_wm_pkg::strb_t             final_strb
);

  // Beat count width after dropping the byte-in-beat bits
  localparam int TOTAL_W = `AXI_WM_SIZE_W - `AXI_WM_BYTE_IDX_W;

  // Low address bits cleared by the 1 KiB alignment
  localparam axi_wm_pkg::addr_t ALIGN_MASK = axi_wm_pkg::addr_t'(`AXI_WM_BURST_BYTES - 1);

  logic                           ctrl_start_d1;
  logic [TOTAL_W-1:0]             total_len_r;
  logic [`AXI_WM_BYTE_IDX_W-1:0]  byte_rem_r;

  //////////////////////////////////////////////////
  // Command capture
  //////////////////////////////////////////////////

  // Start pulse runs two cycles behind the command
  always_ff @(posedge aclk) begin
    if (areset) begin
      ctrl_start_d1 <= 1'b0;
      start         <= 1'b0;
    end else begin
      ctrl_start_d1 <= ctrl_start;
      start         <= ctrl_start_d1;
    end
  end

  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      // Total beats minus one, a partial last beat counts as a full one
      if (|ctrl_xfer_size_in_bytes[`AXI_WM_BYTE_IDX_W-1:0]) begin
        total_len_r <= ctrl_xfer_size_in_bytes[`AXI_WM_SIZE_W-1:`AXI_WM_BYTE_IDX_W];
      end else begin
        total_len_r <= ctrl_xfer_size_in_bytes[`AXI_WM_SIZE_W-1:`AXI_WM_BYTE_IDX_W]
                       - TOTAL_W'(1);
      end
      // Bursts never cross a 1 KiB line
      base_addr  <= ctrl_addr_offset & ~ALIGN_MASK;
      // Index of the last valid byte in the final beat
      // A zero remainder wraps to all ones and keeps every byte
      byte_rem_r <= ctrl_xfer_size_in_bytes[`AXI_WM_BYTE_IDX_W-1:0]
                    - `AXI_WM_BYTE_IDX_W'(1);
    end
  end

  //////////////////////////////////////////////////
  // Derived burst values
  //////////////////////////////////////////////////

  // Updated together with the start pulse, held until the next command
  always_ff @(posedge aclk) begin
    if (ctrl_start_d1) begin
      // Upper bits count whole bursts, lower bits give the last AWLEN
      num_txn   <= total_len_r[`AXI_WM_BURST_IDX_W +: `AXI_WM_TXN_W];
      final_len <= total_len_r[`AXI_WM_BURST_IDX_W-1:0];
      // Low bytes up to the remainder
      for (int i = 0; i < `AXI_WM_STRB_W; i++) begin
        final_strb[i] <= (i <= int'(byte_rem_r));
      end
    end
  end

endmodule

// ==== wm_data_fifo.sv ====
`timescale 1ns/1ps
`include "axi_wm_consts.svh"

module wm_data_fifo #(
  parameter int DEPTH = `AXI_WM_FIFO_DEPTH
) (
  input  logic               aclk,
  input  logic               areset,
  input  logic               wr_valid,
  input  axi_wm_pkg::data_t  wr_data,
  output logic               wr_ready,
  input  logic               rd_pop,
  output logic               rd_valid,
  output axi_wm_pkg::data_t  rd_data
);

  localparam int PTR_W = $clog2(DEPTH);

  axi_wm_pkg::data_t  mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [PTR_W:0]     mem_cnt;
  logic               mem_empty;
  logic               push;
  logic               out_load;
  logic               mem_wr;
  logic               mem_rd;

  // Not full, also the stream ready
  assign wr_ready  = (mem_cnt != (PTR_W + 1)'(DEPTH));
  assign mem_empty = (mem_cnt == '0);
  assign push      = wr_valid & wr_ready;

  // Output slot is free this cycle or being emptied
  assign out_load = ~rd_valid | rd_pop;
  // Empty array and free slot, the word goes straight to the output
  assign mem_wr   = push & ~(out_load & mem_empty);
  assign mem_rd   = out_load & ~mem_empty;

  always_ff @(posedge aclk) begin
    if (mem_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      mem_cnt  <= '0;
      rd_valid <= 1'b0;
    end else begin
      if (mem_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
      end
      if (mem_rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
      end
      case ({mem_wr, mem_rd})
        2'b10:   mem_cnt <= mem_cnt + (PTR_W + 1)'(1);
        2'b01:   mem_cnt <= mem_cnt - (PTR_W + 1)'(1);
        default: mem_cnt <= mem_cnt;
      endcase
      if (out_load) begin
        rd_valid <= ~mem_empty | push;
      end
    end
  end

  // Registered fall-through word
  always_ff @(posedge aclk) begin
    if (out_load) begin
      rd_data <= mem_empty ? wr_data : mem[rd_ptr];
    end
  end

endmodule

// ==== wm_burst_issue.sv ====
`timescale 1ns/1ps
`include "axi_wm_consts.svh"

module wm_burst_issue (
  input  logic                   aclk,
  input  logic                   areset,
  input  logic                   start,
  input  axi_wm_pkg::addr_t      base_addr,
  input  axi_wm_pkg::txn_cnt_t   num_txn,
  input  axi_wm_pkg::beat_idx_t  final_len,
  input  axi_wm_pkg::strb_t      final_strb,
  input  logic                   fifo_valid,
  input  axi_wm_pkg::data_t      fifo_data,
  output logic                   fifo_pop,
  input  logic                   aw_stall,
  output logic                   aw_fire,
  output logic                   awvalid,
  input  logic                   awready,
  output axi_wm_pkg::addr_t      awaddr,
  output axi_wm_pkg::beat_idx_t  awlen,
  output logic                   wvalid,
  input  logic                   wready,
  output axi_wm_pkg::data_t      wdata,
  output axi_wm_pkg::strb_t      wstrb,
  output logic                   wlast
);

  // AWLEN of a full burst
  localparam axi_wm_pkg::beat_idx_t FULL_LEN =
    axi_wm_pkg::beat_idx_t'(`AXI_WM_BURST_BEATS - 1);

  axi_wm_pkg::w_state_t   w_state;
  logic                   wxfer;
  logic                   single_txn;
  logic                   w_final_txn;
  logic                   w_almost_final;
  logic                   w_final_xfer;
  axi_wm_pkg::beat_idx_t  beats_left;
  axi_wm_pkg::txn_cnt_t   w_txn_left;
  logic                   wfirst;
  logic                   wfirst_d1;
  logic                   wfirst_pulse;
  axi_wm_pkg::txn_cnt_t   aw_pending;
  logic                   aw_idle;
  axi_wm_pkg::txn_cnt_t   aw_txn_left;

  //////////////////////////////////////////////////
  // W channel
  //////////////////////////////////////////////////

  // Data only flows once the command has been decoded
  assign wvalid   = fifo_valid & (w_state == axi_wm_pkg::W_RUN);
  assign wdata    = fifo_data;
  assign wxfer    = wvalid & wready;
  assign fifo_pop = wxfer;

  assign single_txn     = (num_txn == '0);
  assign w_final_txn    = (w_txn_left == '0);
  assign w_almost_final = (w_txn_left == axi_wm_pkg::txn_cnt_t'(1));
  assign w_final_xfer   = wxfer & wlast & w_final_txn;

  // Beats counted down, last beat of the burst at zero
  assign wlast = (beats_left == '0);
  // Only the very last beat of the command can be partial
  assign wstrb = (wlast & w_final_txn) ? final_strb : '1;

  always_ff @(posedge aclk) begin
    if (areset) begin
      w_state <= axi_wm_pkg::W_IDLE;
    end else if (start) begin
      w_state <= axi_wm_pkg::W_RUN;
    end else if (w_final_xfer) begin
      w_state <= axi_wm_pkg::W_IDLE;
    end
  end

  // Beat-in-burst counter
  always_ff @(posedge aclk) begin
    if (areset) begin
      beats_left <= FULL_LEN;
    end else if (start) begin
      beats_left <= single_txn ? final_len : FULL_LEN;
    end else if (wxfer & wlast & w_almost_final) begin
      // Next burst is the short one
      beats_left <= final_len;
    end else if (wxfer) begin
      // Wraps from zero back to a full burst
      beats_left <= beats_left - axi_wm_pkg::beat_idx_t'(1);
    end
  end

  // Bursts left on the W side
  always_ff @(posedge aclk) begin
    if (areset) begin
      w_txn_left <= '0;
    end else if (start) begin
      w_txn_left <= num_txn;
    end else if (wxfer & wlast) begin
      w_txn_left <= w_txn_left - axi_wm_pkg::txn_cnt_t'(1);
    end
  end

  // First beat marker and its one-cycle pulse
  always_ff @(posedge aclk) begin
    if (areset) begin
      wfirst       <= 1'b1;
      wfirst_d1    <= 1'b0;
      wfirst_pulse <= 1'b0;
    end else begin
      if (wxfer) begin
        wfirst <= wlast;
      end
      wfirst_d1    <= wvalid & wfirst;
      wfirst_pulse <= wvalid & wfirst & ~wfirst_d1;
    end
  end

  //////////////////////////////////////////////////
  // AW channel
  //////////////////////////////////////////////////

  // Bursts with data on W that still wait for their address
  always_ff @(posedge aclk) begin
    if (areset) begin
      aw_pending <= '0;
    end else begin
      case ({wfirst_pulse, aw_fire})
        2'b10:   aw_pending <= aw_pending + axi_wm_pkg::txn_cnt_t'(1);
        2'b01:   aw_pending <= aw_pending - axi_wm_pkg::txn_cnt_t'(1);
        default: aw_pending <= aw_pending;
      endcase
    end
  end

  assign aw_idle = (aw_pending == '0);
  assign aw_fire = awvalid & awready;

  // Request needs pending data and a free credit, then holds until accepted
  always_ff @(posedge aclk) begin
    if (areset) begin
      awvalid <= 1'b0;
    end else if (~awvalid & ~aw_idle & ~aw_stall) begin
      awvalid <= 1'b1;
    end else if (awready) begin
      awvalid <= 1'b0;
    end
  end

  // Address steps one burst per accepted request
  always_ff @(posedge aclk) begin
    if (start) begin
      awaddr <= base_addr;
    end else if (aw_fire) begin
      awaddr <= awaddr + axi_wm_pkg::addr_t'(`AXI_WM_BURST_BYTES);
    end
  end

  // Bursts left on the AW side
  always_ff @(posedge aclk) begin
    if (areset) begin
      aw_txn_left <= '0;
    end else if (start) begin
      aw_txn_left <= num_txn;
    end else if (aw_fire) begin
      aw_txn_left <= aw_txn_left - axi_wm_pkg::txn_cnt_t'(1);
    end
  end

  assign awlen = (aw_txn_left == '0) ? final_len : FULL_LEN;

endmodule

// ==== wm_resp_tracker.sv ====
`timescale 1ns/1ps
`include "axi_wm_consts.svh"

module wm_resp_tracker (
  input  logic                  aclk,
  input  logic                  areset,
  input  logic                  start,
  input  axi_wm_pkg::txn_cnt_t  num_txn,
  input  logic                  aw_fire,
  input  logic                  bvalid,
  output logic                  bready,
  output logic                  aw_stall,
  output logic                  ctrl_done
);

  logic                          bxfer;
  logic                          b_busy;
  axi_wm_pkg::txn_cnt_t          b_txn_left;
  logic                          b_final;
  logic [`AXI_WM_CREDIT_W-1:0]   credits;

  // Responses are always accepted
  assign bready  = 1'b1;
  assign bxfer   = bvalid & bready;
  assign b_final = (b_txn_left == '0);

  //////////////////////////////////////////////////
  // Completion
  //////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (areset) begin
      b_txn_left <= '0;
      b_busy     <= 1'b0;
      ctrl_done  <= 1'b0;
    end else begin
      if (start) begin
        b_txn_left <= num_txn;
      end else if (bxfer) begin
        b_txn_left <= b_txn_left - axi_wm_pkg::txn_cnt_t'(1);
      end
      // Busy from start to the last response
      if (start) begin
        b_busy <= 1'b1;
      end else if (bxfer & b_final) begin
        b_busy <= 1'b0;
      end
      // One cycle after the final response
      ctrl_done <= bxfer & b_final & b_busy;
    end
  end

  //////////////////////////////////////////////////
  // Outstanding burst credits
  //////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (areset) begin
      credits <= `AXI_WM_CREDIT_W'(`AXI_WM_MAX_OUTSTANDING);
    end else begin
      case ({aw_fire, bxfer})
        2'b10:   credits <= credits - `AXI_WM_CREDIT_W'(1);
        2'b01:   credits <= credits + `AXI_WM_CREDIT_W'(1);
        default: credits <= credits;
      endcase
    end
  end

  // No new address request once all credits are out
  assign aw_stall = (credits == '0);

endmodule

// ==== axi_write_master.sv ====
`timescale 1ns/1ps
`include "axi_wm_consts.svh"

module axi_write_master (
  input  logic                          aclk,
  input  logic                          areset,
  // Command
  input  logic                          ctrl_start,
  output logic                          ctrl_done,
  input  axi_wm_pkg::addr_t             ctrl_addr_offset,
  input  logic [`AXI_WM_SIZE_W-1:0]     ctrl_xfer_size_in_bytes,
  // AW channel
  output logic                          awvalid,
  input  logic                          awready,
  output axi_wm_pkg::addr_t             awaddr,
  output axi_wm_pkg::beat_idx_t         awlen,
  // W channel
  output logic                          wvalid,
  input  logic                          wready,
  output axi_wm_pkg::data_t             wdata,
  output axi_wm_pkg::strb_t             wstrb,
  output logic                          wlast,
  // B channel
  input  logic                          bvalid,
  output logic                          bready,
  // Stream input
  input  logic                          s_axis_tvalid,
  output logic                          s_axis_tready,
  input  axi_wm_pkg::data_t             s_axis_tdata
);

  // Decoded command
  logic                   start;
  axi_wm_pkg::addr_t      base_addr;
  axi_wm_pkg::txn_cnt_t   num_txn;
  axi_wm_pkg::beat_idx_t  final_len;
  axi_wm_pkg::strb_t      final_strb;

  // FIFO read side
  logic                   fifo_valid;
  axi_wm_pkg::data_t      fifo_data;
  logic                   fifo_pop;

  // Credit handshake between issue and response stages
  logic                   aw_fire;
  logic                   aw_stall;

  wm_cmd_decode i_cmd_decode (
    .aclk                    (aclk),
    .areset                  (areset),
    .ctrl_start              (ctrl_start),
    .ctrl_addr_offset        (ctrl_addr_offset),
    .ctrl_xfer_size_in_bytes (ctrl_xfer_size_in_bytes),
    .start                   (start),
    .base_addr               (base_addr),
    .num_txn                 (num_txn),
    .final_len               (final_len),
    .final_strb              (final_strb)
  );

  wm_data_fifo #(
    .DEPTH (`AXI_WM_FIFO_DEPTH)
  ) i_data_fifo (
    .aclk     (aclk),
    .areset   (areset),
    .wr_valid (s_axis_tvalid),
    .wr_data  (s_axis_tdata),
    .wr_ready (s_axis_tready),
    .rd_pop   (fifo_pop),
    .rd_valid (fifo_valid),
    .rd_data  (fifo_data)
  );

  wm_burst_issue i_burst_issue (
    .aclk       (aclk),
    .areset     (areset),
    .start      (start),
    .base_addr  (base_addr),
    .num_txn    (num_txn),
    .final_len  (final_len),
    .final_strb (final_strb),
    .fifo_valid (fifo_valid),
    .fifo_data  (fifo_data),
    .fifo_pop   (fifo_pop),
    .aw_stall   (aw_stall),
    .aw_fire    (aw_fire),
    .awvalid    (awvalid),
    .awready    (awready),
    .awaddr     (awaddr),
    .awlen      (awlen),
    .wvalid     (wvalid),
    .wready     (wready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wlast      (wlast)
  );

  wm_resp_tracker i_resp_tracker (
    .aclk      (aclk),
    .areset    (areset),
    .start     (start),
    .num_txn   (num_txn),
    .aw_fire   (aw_fire),
    .bvalid    (bvalid),
    .bready    (bready),
    .aw_stall  (aw_stall),
    .ctrl_done (ctrl_done)
  );

endmodule

// ==== tb_axi_write_master_props.sv ====
`timescale 1ns/1ps
`include "axi_wm_consts.svh"

module tb_axi_write_master_props (
  input logic                   aclk,
  input logic                   areset,
  input logic                   start,
  input logic                   ctrl_done,
  input logic                   awvalid,
  input logic                   awready,
  input axi_wm_pkg::addr_t      awaddr,
  input axi_wm_pkg::beat_idx_t  awlen,
  input logic                   wvalid,
  input logic                   wready,
  input axi_wm_pkg::data_t      wdata,
  input axi_wm_pkg::strb_t      wstrb,
  input logic                   wlast,
  input logic                   bvalid,
  input logic                   bready
);

  // Bursts with an accepted address and no response yet
  int unsigned  outstanding;
  // Set by the first decoded command
  logic         started;

  always_ff @(posedge aclk) begin
    if (areset) begin
      outstanding <= 0;
      started     <= 1'b0;
    end else begin
      if (start) begin
        started <= 1'b1;
      end
      case ({awvalid && awready, bvalid && bready})
        2'b10:   outstanding <= outstanding + 1;
        2'b01:   outstanding <= outstanding - 1;
        default: outstanding <= outstanding;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Channel stability
  //////////////////////////////////////////////////

  aw_hold: assert property (@(posedge aclk) disable iff (areset)
    awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen))
    else $error("AW request dropped or changed before awready");

  w_hold: assert property (@(posedge aclk) disable iff (areset)
    wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb) && $stable(wlast))
    else $error("W beat dropped or changed before wready");

  //////////////////////////////////////////////////
  // Credits, completion, idle after reset
  //////////////////////////////////////////////////

  credit_limit: assert property (@(posedge aclk) disable iff (areset)
    outstanding <= `AXI_WM_MAX_OUTSTANDING)
    else $error("more bursts outstanding than the credit limit allows");

  done_pulse: assert property (@(posedge aclk) disable iff (areset)
    ctrl_done |=> !ctrl_done)
    else $error("ctrl_done high for more than one cycle");

  // Done follows an accepted response one cycle earlier
  done_after_b: assert property (@(posedge aclk) disable iff (areset)
    ctrl_done |-> $past(bvalid && bready))
    else $error("ctrl_done without a write response in the cycle before");

  quiet_before_start: assert property (@(posedge aclk) disable iff (areset)
    !started |-> !wvalid && !awvalid && !ctrl_done)
    else $error("AXI activity or done before the first command");

endmodule

// ==== tb_axi_write_master.sv ====
`timescale 1ns/1ps
`include "axi_wm_consts.svh"

module tb_axi_write_master;

  localparam time CLK_PERIOD      = 100ns;
  localparam time DRIVE_DELAY     = 1ns;
  localparam int  RESET_CYCLES    = 16;
  localparam int  NUM_TESTS       = 4;
  localparam int  CYCLES_PER_BEAT = 20;
  localparam int  PRELOAD_CYCLES  = 4;
  localparam int  HOLD_CYCLES     = 40;
  localparam int  TAIL_CYCLES     = 8;

  logic                         aclk;
  logic                         areset;
  logic                         ctrl_start;
  logic                         ctrl_done;
  axi_wm_pkg::addr_t            ctrl_addr_offset;
  logic [`AXI_WM_SIZE_W-1:0]    ctrl_xfer_size_in_bytes;
  logic                         awvalid;
  logic                         awready;
  axi_wm_pkg::addr_t            awaddr;
  axi_wm_pkg::beat_idx_t        awlen;
  logic                         wvalid;
  logic                         wready;
  axi_wm_pkg::data_t            wdata;
  axi_wm_pkg::strb_t            wstrb;
  logic                         wlast;
  logic                         bvalid;
  logic                         bready;
  logic                         s_axis_tvalid;
  logic                         s_axis_tready;
  axi_wm_pkg::data_t            s_axis_tdata;

  // Test table with the second address off the 1 KiB grid
  int unsigned        test_size [NUM_TESTS] = '{16, 1027, 4096, 70000};
  axi_wm_pkg::addr_t  test_addr [NUM_TESTS] = '{32'h0000_1000, 32'h0002_0123,
                                                32'h0010_0000, 32'h0040_0000};
  string              test_name [NUM_TESTS] = '{"size_16", "size_1027_misaligned",
                                                "size_4096", "size_70000_credits"};

  integer                 seed = 32'he711;

  // Expected values of the running test
  string                  cur_test = "reset";
  axi_wm_pkg::addr_t      exp_base;
  int unsigned            exp_beats;
  int unsigned            exp_bursts;
  axi_wm_pkg::beat_idx_t  exp_last_len;
  axi_wm_pkg::strb_t      exp_last_strb;
  logic                   hold_b = 1'b0;

  // Running totals from the monitor and per-test bases from the sequencer
  int unsigned            stream_total = 0;
  int unsigned            stream_sent = 0;
  logic                   s_fire = 1'b0;
  int unsigned            aw_total = 0;
  int unsigned            w_total = 0;
  int unsigned            wlast_total = 0;
  int unsigned            b_total = 0;
  int unsigned            done_total = 0;
  int unsigned            aw_base = 0;
  int unsigned            w_base = 0;
  int unsigned            b_base = 0;
  int unsigned            done_base = 0;
  int                     mon_checks = 0;
  int                     mon_errors = 0;
  int                     seq_checks = 0;
  int                     seq_errors = 0;

  axi_write_master i_dut (
    .aclk                    (aclk),
    .areset                  (areset),
    .ctrl_start              (ctrl_start),
    .ctrl_done               (ctrl_done),
    .ctrl_addr_offset        (ctrl_addr_offset),
    .ctrl_xfer_size_in_bytes (ctrl_xfer_size_in_bytes),
    .awvalid                 (awvalid),
    .awready                 (awready),
    .awaddr                  (awaddr),
    .awlen                   (awlen),
    .wvalid                  (wvalid),
    .wready                  (wready),
    .wdata                   (wdata),
    .wstrb                   (wstrb),
    .wlast                   (wlast),
    .bvalid                  (bvalid),
    .bready                  (bready),
    .s_axis_tvalid           (s_axis_tvalid),
    .s_axis_tready           (s_axis_tready),
    .s_axis_tdata            (s_axis_tdata)
  );

  bind axi_write_master tb_axi_write_master_props i_props (
    .aclk      (aclk),
    .areset    (areset),
    .start     (start),
    .ctrl_done (ctrl_done),
    .awvalid   (awvalid),
    .awready   (awready),
    .awaddr    (awaddr),
    .awlen     (awlen),
    .wvalid    (wvalid),
    .wready    (wready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wlast     (wlast),
    .bvalid    (bvalid),
    .bready    (bready)
  );

  //////////////////////////////////////////////////
  // Expected values from byte count
  //////////////////////////////////////////////////

  // Whole 32-bit beats with a partial last beat rounded up
  function automatic int unsigned beats_of(input int unsigned size);
    return (size + 3) / 4;
  endfunction

  function automatic int unsigned bursts_of(input int unsigned size);
    return (beats_of(size) + `AXI_WM_BURST_BEATS - 1) / `AXI_WM_BURST_BEATS;
  endfunction

  // Low bytes of the last beat or all four on an even multiple
  function automatic axi_wm_pkg::strb_t strb_of(input int unsigned size);
    if (size % 4 == 0) begin
      return 4'hf;
    end
    return axi_wm_pkg::strb_t'((1 << (size % 4)) - 1);
  endfunction

  //////////////////////////////////////////////////
  // Monitor checks
  //////////////////////////////////////////////////

  task automatic check_aw(input int unsigned idx);
    axi_wm_pkg::addr_t      addr_exp;
    axi_wm_pkg::beat_idx_t  len_exp;
    addr_exp = exp_base + axi_wm_pkg::addr_t'(idx * `AXI_WM_BURST_BYTES);
    len_exp  = (idx == exp_bursts - 1) ? exp_last_len : 8'd255;
    mon_checks++;
    assert (idx < exp_bursts) else begin
      mon_errors++;
      $display("%s: address request %0d beyond the %0d bursts of the command",
               cur_test, idx, exp_bursts);
    end
    assert (awaddr == addr_exp) else begin
      mon_errors++;
      $display("error %s awaddr burst %0d: expected %h, actual %h",
               cur_test, idx, addr_exp, awaddr);
    end
    assert (awlen == len_exp) else begin
      mon_errors++;
      $display("error %s awlen burst %0d: expected %0d, actual %0d",
               cur_test, idx, len_exp, awlen);
    end
  endtask

  task automatic check_w(input int unsigned idx);
    axi_wm_pkg::data_t  data_exp;
    axi_wm_pkg::strb_t  strb_exp;
    logic               last_exp;
    // Stream words count up from zero over the whole run
    data_exp = axi_wm_pkg::data_t'(w_total);
    last_exp = ((idx % `AXI_WM_BURST_BEATS) == `AXI_WM_BURST_BEATS - 1) ||
               (idx == exp_beats - 1);
    strb_exp = (idx == exp_beats - 1) ? exp_last_strb : 4'hf;
    mon_checks++;
    assert (idx < exp_beats) else begin
      mon_errors++;
      $display("%s: write beat %0d after all %0d beats of the command",
               cur_test, idx, exp_beats);
    end
    assert (wdata == data_exp) else begin
      mon_errors++;
      $display("error %s wdata beat %0d: expected %h, actual %h", cur_test, idx, data_exp, wdata);
    end
    assert (wlast == last_exp) else begin
      mon_errors++;
      $display("error %s wlast beat %0d: expected %b, actual %b", cur_test, idx, last_exp, wlast);
    end
    assert (wstrb == strb_exp) else begin
      mon_errors++;
      $display("error %s wstrb beat %0d: expected %h, actual %h", cur_test, idx, strb_exp, wstrb);
    end
  endtask

  // Handshakes are sampled mid-cycle and complete on the next rising edge
  always @(negedge aclk) begin
    if (!areset) begin
      s_fire = s_axis_tvalid && s_axis_tready;
      if (awvalid && awready) begin
        check_aw(aw_total - aw_base);
        aw_total++;
      end
      if (wvalid && wready) begin
        check_w(w_total - w_base);
        w_total++;
        if (wlast) begin
          wlast_total++;
        end
      end
      if (bvalid && bready) begin
        b_total++;
      end
      if (ctrl_done) begin
        mon_checks++;
        assert (b_total - b_base == exp_bursts) else begin
          mon_errors++;
          $display("error %s responses at done: expected %0d, actual %0d",
                   cur_test, exp_bursts, b_total - b_base);
        end
        done_total++;
      end
    end
  end

  //////////////////////////////////////////////////
  // Clock, stream source and slave model
  //////////////////////////////////////////////////

  initial begin
    aclk = 1'b0;
    forever #(CLK_PERIOD / 2) aclk = ~aclk;
  end

  initial begin
    awready       = 1'b0;
    wready        = 1'b0;
    bvalid        = 1'b0;
    s_axis_tvalid = 1'b0;
    s_axis_tdata  = '0;
    forever begin
      @(posedge aclk);
      #DRIVE_DELAY;
      if (s_fire) begin
        stream_sent++;
      end
      // Counter data limited to the words the tests asked for
      s_axis_tvalid = (stream_sent < stream_total);
      s_axis_tdata  = axi_wm_pkg::data_t'(stream_sent);
      awready       = ($random(seed) & 1) != 0;
      wready        = ($random(seed) & 3) != 0;
      // One response per burst once both its address and its wlast are in
      bvalid = !hold_b && ((aw_total < wlast_total ? aw_total : wlast_total) > b_total);
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  task automatic compare_count(input string what, input int unsigned expected,
                               input int unsigned actual);
    seq_checks++;
    assert (actual == expected) else begin
      seq_errors++;
      $display("error %s %s: expected %0d, actual %0d", cur_test, what, expected, actual);
    end
  endtask

  // Responses held back until the first burst beyond the credits has its data on W
  task automatic check_credit_limit();
    wait (w_total - w_base > `AXI_WM_MAX_OUTSTANDING * `AXI_WM_BURST_BEATS);
    repeat (HOLD_CYCLES) @(posedge aclk);
    compare_count("bursts accepted with no credits", `AXI_WM_MAX_OUTSTANDING,
                  aw_total - aw_base);
    @(negedge aclk);
    #DRIVE_DELAY;
    hold_b = 1'b0;
  endtask

  task automatic run_test(input int t);
    int unsigned size;
    size = test_size[t];
    // Set up between edges away from the drive and sample slots
    @(negedge aclk);
    #DRIVE_DELAY;
    cur_test      = test_name[t];
    exp_base      = test_addr[t] & ~axi_wm_pkg::addr_t'(`AXI_WM_BURST_BYTES - 1);
    exp_beats     = beats_of(size);
    exp_bursts    = bursts_of(size);
    exp_last_len  = axi_wm_pkg::beat_idx_t'((exp_beats - 1) % `AXI_WM_BURST_BEATS);
    exp_last_strb = strb_of(size);
    aw_base       = aw_total;
    w_base        = w_total;
    b_base        = b_total;
    done_base     = done_total;
    hold_b        = (exp_bursts > `AXI_WM_MAX_OUTSTANDING);
    stream_total  = stream_total + exp_beats;
    // Stream data already waits in the FIFO when the command comes
    repeat (PRELOAD_CYCLES) @(posedge aclk);
    #DRIVE_DELAY;
    ctrl_start              = 1'b1;
    ctrl_addr_offset        = test_addr[t];
    ctrl_xfer_size_in_bytes = size;
    @(posedge aclk);
    #DRIVE_DELAY;
    ctrl_start = 1'b0;
    if (hold_b) begin
      check_credit_limit();
    end
    wait (done_total != done_base);
    // Room for a second done pulse to show up
    repeat (TAIL_CYCLES) @(posedge aclk);
    compare_count("write beats", exp_beats, w_total - w_base);
    compare_count("address requests", exp_bursts, aw_total - aw_base);
    compare_count("done pulses", 1, done_total - done_base);
  endtask

  initial begin
    areset                  = 1'b1;
    ctrl_start              = 1'b0;
    ctrl_addr_offset        = '0;
    ctrl_xfer_size_in_bytes = '0;
    repeat (RESET_CYCLES) @(posedge aclk);
    #DRIVE_DELAY;
    areset = 1'b0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("tests: %0d, checks: %0d, errors: %0d", NUM_TESTS,
             mon_checks + seq_checks, mon_errors + seq_errors);
    if (mon_errors + seq_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Limit scales with the beats of all tests
  initial begin : watchdog
    int unsigned limit_cycles;
    limit_cycles = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      limit_cycles += beats_of(test_size[t]) * CYCLES_PER_BEAT;
    end
    repeat (limit_cycles) @(posedge aclk);
    $display("watchdog expired after %0d cycles with the tests still running", limit_cycles);
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+.
axi_wm_pkg.sv
wm_cmd_decode.sv
wm_data_fifo.sv
wm_burst_issue.sv
wm_resp_tracker.sv
axi_write_master.sv
tb_axi_write_master_props.sv
tb_axi_write_master.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f files.f --top-module tb_axi_write_master
out=$(./obj_dir/Vtb_axi_write_master) || { echo "$out"; exit 1; }
echo "$out"
if echo "$out" | grep -qx "Simulation passed"; then
  exit 0
else
  exit 1
fi
